// ==== logic/flashLoadPkg.sv ====
// Flash loader package with flash commands, field widths and stage structs
package flashLoadPkg;

  // Flash byte address and ROM word address widths
  localparam int flashAddrW = 24;
  localparam int memAddrW = 29;

  // SPI flash read opcode
  localparam logic [7:0] flashReadCmd = 8'h03;
  // Sent on MOSI while data bytes are clocked in
  localparam logic [7:0] flashDummyByte = 8'hFF;

  // Sequencer to SPI engine
  typedef struct packed {
    logic       send;
    logic [7:0] txByte;
  } spiReqT;

  // SPI engine to sequencer and packer
  typedef struct packed {
    logic       busy;
    logic       recv;
    logic [7:0] rxByte;
  } spiRspT;

  // Packer to ROM write port
  typedef struct packed {
    logic                access;
    logic                wrEn;
    logic [memAddrW-1:0] addr;
    logic [63:0]         data;
  } memWriteT;

endpackage

// ==== logic/spiByteEngine.sv ====
// SPI mode-0 byte engine, sends and receives one byte per request
`timescale 1ns/10ps

module spiByteEngine #(
  parameter int unsigned baudDiv = 1
) (
  input  logic                 AClkH,
  input  logic                 arstN,
  input  flashLoadPkg::spiReqT spiReq,
  input  logic                 flashMiso,
  output flashLoadPkg::spiRspT spiRsp,
  output logic                 flashSck,
  output logic                 flashMosi
);

  localparam int divW      = (baudDiv > 0) ? $clog2(baudDiv + 1) : 1;
  localparam int byteTicks = 16 * (baudDiv + 1);
  localparam int tickW     = $clog2(byteTicks);
  // Final busy cycle, recv then lands byteTicks after the send cycle
  localparam int lastTick  = byteTicks - 2;

  logic             busyQ;
  logic             recvQ;
  logic             sckQ;
  logic [divW-1:0]  divCnt;
  logic [tickW-1:0] tickCnt;
  logic [7:0]       txShift;
  logic [7:0]       rxShift;
  logic             halfEnd;
  logic             finish;

  assign halfEnd = (divCnt == divW'(baudDiv));
  assign finish  = (tickCnt == tickW'(lastTick));

  always_ff @(posedge AClkH or negedge arstN) begin
    if (!arstN) begin
      busyQ   <= 1'b0;
      recvQ   <= 1'b0;
      sckQ    <= 1'b0;
      divCnt  <= '0;
      tickCnt <= '0;
      txShift <= '0;
    end else begin
      recvQ <= 1'b0;
      if (!busyQ) begin
        // Idle, SCK parked low
        sckQ    <= 1'b0;
        divCnt  <= '0;
        tickCnt <= '0;
        if (spiReq.send) begin
          busyQ   <= 1'b1;
          txShift <= spiReq.txByte;
        end
      end else begin
        tickCnt <= tickCnt + 1'b1;
        if (halfEnd) begin
          divCnt <= '0;
          sckQ   <= ~sckQ;
          // Next bit on the falling edge
          if (sckQ) begin
            txShift <= {txShift[6:0], 1'b0};
          end
        end else begin
          divCnt <= divCnt + 1'b1;
        end
        if (finish) begin
          busyQ <= 1'b0;
          recvQ <= 1'b1;
        end
      end
    end
  end

  // Sample MISO on the rising edge, MSB first
  always_ff @(posedge AClkH) begin
    if (busyQ && halfEnd && !sckQ) begin
      rxShift <= {rxShift[6:0], flashMiso};
    end
  end

  assign spiRsp    = '{busy: busyQ, recv: recvQ, rxByte: rxShift};
  assign flashSck  = sckQ;
  assign flashMosi = txShift[7];

endmodule

// ==== logic/romWordPacker.sv ====
// ROM word packer, builds 64-bit words from flash bytes and writes them to ROM
`timescale 1ns/10ps

module romWordPacker #(
  parameter logic [31:0] romBase = 32'h0000_0000,
  parameter int unsigned romWords = 1024
) (
  input  logic                   AClkH,
  input  logic                   arstN,
  input  logic                   wordStart,
  input  logic                   byteAccept,
  input  logic                   wordWrite,
  input  logic                   loading,
  input  flashLoadPkg::spiRspT   spiRsp,
  output logic                   lastWord,
  output flashLoadPkg::memWriteT memWrite
);
  import flashLoadPkg::*;

  // ROM base as a word address
  localparam logic [memAddrW-1:0] baseWord = romBase[31:3];
  localparam logic [memAddrW-1:0] lastIdx  = memAddrW'(romWords - 1);

  logic [63:0]         wordShift;
  logic [memAddrW-1:0] wordIdx;
  logic                wrEnQ;
  logic [memAddrW-1:0] addrQ;
  logic [63:0]         dataQ;

  // First byte ends up in bits 7:0
  always_ff @(posedge AClkH) begin
    if (byteAccept) begin
      wordShift <= {spiRsp.rxByte, wordShift[63:8]};
    end
  end

  always_ff @(posedge AClkH or negedge arstN) begin
    if (!arstN) begin
      wrEnQ   <= 1'b0;
      wordIdx <= '0;
    end else begin
      wrEnQ <= wordWrite;
      // Index moves on after the write strobe so lastWord covers the advance step
      if (wordStart) begin
        wordIdx <= '0;
      end else if (wrEnQ) begin
        wordIdx <= wordIdx + 1'b1;
      end
    end
  end

  always_ff @(posedge AClkH) begin
    if (wordWrite) begin
      addrQ <= baseWord + wordIdx;
      dataQ <= wordShift;
    end
  end

  assign lastWord = (wordIdx == lastIdx);

  assign memWrite = '{access: loading, wrEn: wrEnQ, addr: addrQ, data: dataQ};

endmodule

// ==== logic/loadSequencer.sv ====
// Load sequencer, one-hot FSM ordering flash header, data bytes and ROM writes
`timescale 1ns/10ps

module loadSequencer #(
  parameter logic [flashLoadPkg::flashAddrW-1:0] progStart = 24'h800000
) (
  input  logic                 AClkH,
  input  logic                 arstN,
  input  logic                 loadStart,
  input  flashLoadPkg::spiRspT spiRsp,
  input  logic                 lastWord,
  output flashLoadPkg::spiReqT spiReq,
  output logic                 wordStart,
  output logic                 wordWrite,
  output logic                 byteAccept,
  output logic                 loading,
  output logic                 flashNcs,
  output logic                 flashMaster
);
  import flashLoadPkg::*;

  // One-hot state bits
  localparam int stStart   = 0;
  localparam int stCmd     = 1;
  localparam int stAddrHi  = 2;
  localparam int stAddrMid = 3;
  localparam int stAddrLo  = 4;
  localparam int stDataReq = 5;
  localparam int stDataAcc = 6;
  localparam int stRomWr   = 7;
  localparam int stAdvance = 8;
  localparam int stEnd     = 9;
  localparam int stDone    = 10;
  localparam int stCount   = 11;

  logic [stCount-1:0] state;
  logic [stCount-1:0] nextState;
  logic [stCount-1:0] go;
  logic [stCount-1:0] stay;
  logic [2:0]         byteIdx;
  logic               lastByte;
  logic               busy;
  logic               ncsQ;
  logic               masterQ;

  assign busy     = spiRsp.busy;
  assign lastByte = (byteIdx == 3'd7);

  // go marks entry into a state, stay holds it while the SPI byte runs
  always_comb begin
    go   = '0;
    stay = '0;

    go[stStart] = loadStart & ~(|state);

    // Read command and 24-bit address
    go[stCmd]       = state[stStart];
    stay[stCmd]     = state[stCmd] & busy;
    go[stAddrHi]    = state[stCmd] & ~busy;
    stay[stAddrHi]  = state[stAddrHi] & busy;
    go[stAddrMid]   = state[stAddrHi] & ~busy;
    stay[stAddrMid] = state[stAddrMid] & busy;
    go[stAddrLo]    = state[stAddrMid] & ~busy;
    stay[stAddrLo]  = state[stAddrLo] & busy;

    // Data bytes, eight per word
    go[stDataReq]   = (state[stAddrLo] & ~busy) |
                      (state[stDataAcc] & ~lastByte) |
                      (state[stAdvance] & ~lastWord);
    stay[stDataReq] = state[stDataReq] & busy;
    go[stDataAcc]   = state[stDataReq] & ~busy;

    go[stRomWr]   = state[stDataAcc] & lastByte;
    go[stAdvance] = state[stRomWr];
    go[stEnd]     = state[stAdvance] & lastWord;
    go[stDone]    = state[stEnd];
  end

  assign nextState = go | stay;

  always_ff @(posedge AClkH or negedge arstN) begin
    if (!arstN) begin
      state   <= '0;
      byteIdx <= '0;
      ncsQ    <= 1'b1;
      masterQ <= 1'b0;
    end else begin
      state <= nextState;
      // Chip select spans command through word advance
      ncsQ    <= ~(|nextState[stAdvance:stCmd]);
      masterQ <= |nextState;
      if (state[stStart]) begin
        byteIdx <= '0;
      end else if (state[stDataAcc]) begin
        byteIdx <= byteIdx + 3'd1;
      end
    end
  end

  // Byte goes out on the cycle a send state is entered
  always_comb begin
    spiReq.send   = |{go[stCmd], go[stAddrHi], go[stAddrMid], go[stAddrLo], go[stDataReq]};
    spiReq.txByte = ({8{go[stCmd]}}     & flashReadCmd) |
                    ({8{go[stAddrHi]}}  & progStart[23:16]) |
                    ({8{go[stAddrMid]}} & progStart[15:8]) |
                    ({8{go[stAddrLo]}}  & progStart[7:0]) |
                    ({8{go[stDataReq]}} & flashDummyByte);
  end

  assign wordStart   = state[stStart];
  assign wordWrite   = state[stRomWr];
  assign byteAccept  = state[stDataAcc];
  assign loading     = |state;
  assign flashNcs    = ncsQ;
  assign flashMaster = masterQ;

endmodule

// ==== logic/flashLoader.sv ====
// Flash loader top, copies a program image from SPI flash into on-chip ROM
`timescale 1ns/10ps

module flashLoader #(
  parameter int unsigned baudDiv = 1,
  parameter logic [31:0] romBase = 32'h0000_0000,
  parameter int unsigned romWords = 1024,
  parameter logic [flashLoadPkg::flashAddrW-1:0] progStart = 24'h800000
) (
  input  logic                            AClkH,
  input  logic                            arstN,
  input  logic                            loadStart,
  input  logic                            flashMiso,
  output logic                            active,
  output logic                            flashMaster,
  output logic                            flashNcs,
  output logic                            flashSck,
  output logic                            flashMosi,
  output logic                            memAccess,
  output logic                            memWrEn,
  output logic [flashLoadPkg::memAddrW-1:0] memAddr,
  output logic [63:0]                     memData
);
  import flashLoadPkg::*;

  spiReqT   spiReq;
  spiRspT   spiRsp;
  memWriteT memWrite;
  logic     wordStart;
  logic     wordWrite;
  logic     byteAccept;
  logic     lastWord;

  loadSequencer #(.progStart(progStart)) sequencer_i (
    .AClkH      (AClkH),
    .arstN      (arstN),
    .loadStart  (loadStart),
    .spiRsp     (spiRsp),
    .lastWord   (lastWord),
    .spiReq     (spiReq),
    .wordStart  (wordStart),
    .wordWrite  (wordWrite),
    .byteAccept (byteAccept),
    .loading    (active),
    .flashNcs   (flashNcs),
    .flashMaster(flashMaster)
  );

  spiByteEngine #(.baudDiv(baudDiv)) spi_i (
    .AClkH    (AClkH),
    .arstN    (arstN),
    .spiReq   (spiReq),
    .flashMiso(flashMiso),
    .spiRsp   (spiRsp),
    .flashSck (flashSck),
    .flashMosi(flashMosi)
  );

  romWordPacker #(.romBase(romBase), .romWords(romWords)) packer_i (
    .AClkH     (AClkH),
    .arstN     (arstN),
    .wordStart (wordStart),
    .byteAccept(byteAccept),
    .wordWrite (wordWrite),
    .loading   (active),
    .spiRsp    (spiRsp),
    .lastWord  (lastWord),
    .memWrite  (memWrite)
  );

  // ROM port pins
  assign memAccess = memWrite.access;
  assign memWrEn   = memWrite.wrEn;
  assign memAddr   = memWrite.addr;
  assign memData   = memWrite.data;

endmodule

// ==== verification/tbClockGen.sv ====
// Testbench clock and reset generator, 40 ns clock with reset held for five cycles
`timescale 1ns/10ps

module tbClockGen #(
  parameter int halfPeriod = 20,
  parameter int resetCycles = 5
) (
  output logic AClkH,
  output logic arstN
);

  initial begin
    AClkH = 1'b0;
    forever #(halfPeriod) AClkH = ~AClkH;
  end

  // Release a little after the edge so the DUT sees a clean deassertion
  initial begin
    arstN = 1'b0;
    repeat (resetCycles) @(posedge AClkH);
    #1 arstN = 1'b1;
  end

endmodule

// ==== verification/spiFlashModel.sv ====
// Behavioral SPI flash, checks the read header and returns reference data bytes
`timescale 1ns/10ps

module spiFlashModel #(
  parameter logic [23:0] progStart = 24'h800000
) (
  input  logic flashNcs,
  input  logic flashSck,
  input  logic flashMosi,
  output logic flashMiso,
  output logic headerError,
  output int   headerCount
);

  localparam logic [7:0]  readCmd = 8'h03;
  localparam logic [31:0] seed    = 32'd2;

  int          bitCnt = 0;
  int          byteCnt = 0;
  logic [7:0]  inShift = '0;
  logic [7:0]  outShift = '0;
  logic [23:0] readAddr = '0;

  function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [7:0] flashByte(input logic [23:0] addr);
    logic [31:0] s;
    s = xorshiftStep({8'h00, addr} ^ seed);
    return s[7:0];
  endfunction

  // Opcode, then start address MSB first
  function automatic logic [7:0] headerByte(input int n);
    case (n)
      0:       return readCmd;
      1:       return progStart[23:16];
      2:       return progStart[15:8];
      default: return progStart[7:0];
    endcase
  endfunction

  initial begin
    flashMiso   = 1'b0;
    headerError = 1'b0;
    headerCount = 0;
  end

  always @(negedge flashNcs) begin
    bitCnt  = 0;
    byteCnt = 0;
  end

  // Mode 0, MOSI taken on the rising edge
  always @(posedge flashSck) begin
    if (flashNcs === 1'b0) begin
      inShift = {inShift[6:0], flashMosi};
      bitCnt  = bitCnt + 1;
      if (bitCnt == 8) begin
        bitCnt = 0;
        if (byteCnt < 4) begin
          if (inShift !== headerByte(byteCnt)) begin
            $display("FAILED flash header byte %0d: expected %h actual %h",
                     byteCnt, headerByte(byteCnt), inShift);
            headerError = 1'b1;
          end
          if (byteCnt > 0) begin
            readAddr = {readAddr[15:0], inShift};
          end
          if (byteCnt == 3) begin
            headerCount = headerCount + 1;
          end
        end
        byteCnt = byteCnt + 1;
      end
    end
  end

  // Next MISO bit ahead of the following rising edge
  always @(negedge flashSck) begin
    if (flashNcs === 1'b0) begin
      if (bitCnt == 0 && byteCnt >= 4) begin
        outShift = flashByte(readAddr + 24'(byteCnt - 4));
      end else begin
        outShift = {outShift[6:0], 1'b0};
      end
      flashMiso = outShift[7];
    end
  end

endmodule

// ==== verification/flashLoaderTb.sv ====
// Flash loader testbench, loads a reference image and checks every ROM write
`timescale 1ns/10ps

module flashLoaderTb;

  localparam int          baudDiv     = 1;
  localparam int          romWords    = 6;
  localparam logic [31:0] romBase     = 32'h100;
  localparam logic [23:0] progStart   = 24'h800000;
  localparam int          memAddrW    = 29;
  localparam logic [31:0] seed        = 32'd2;
  localparam int          loadTimeout = 5000;

  logic                AClkH;
  logic                arstN;
  logic                loadStart;
  logic                flashMiso;
  logic                active;
  logic                flashMaster;
  logic                flashNcs;
  logic                flashSck;
  logic                flashMosi;
  logic                memAccess;
  logic                memWrEn;
  logic [memAddrW-1:0] memAddr;
  logic [63:0]         memData;
  logic                headerError;
  int                  headerCount;

  int writeIdx = 0;

  tbClockGen clockGen_i (.AClkH(AClkH), .arstN(arstN));

  spiFlashModel #(.progStart(progStart)) flashModel_i (
    .flashNcs   (flashNcs),
    .flashSck   (flashSck),
    .flashMosi  (flashMosi),
    .flashMiso  (flashMiso),
    .headerError(headerError),
    .headerCount(headerCount)
  );

  flashLoader #(
    .baudDiv  (baudDiv),
    .romBase  (romBase),
    .romWords (romWords),
    .progStart(progStart)
  ) dut_i (
    .AClkH      (AClkH),
    .arstN      (arstN),
    .loadStart  (loadStart),
    .flashMiso  (flashMiso),
    .active     (active),
    .flashMaster(flashMaster),
    .flashNcs   (flashNcs),
    .flashSck   (flashSck),
    .flashMosi  (flashMosi),
    .memAccess  (memAccess),
    .memWrEn    (memWrEn),
    .memAddr    (memAddr),
    .memData    (memData)
  );

  function automatic logic [31:0] xorshiftStep(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic logic [7:0] flashByte(input logic [23:0] addr);
    logic [31:0] s;
    s = xorshiftStep({8'h00, addr} ^ seed);
    return s[7:0];
  endfunction

  // Word i from flash bytes progStart+8i onwards with the first byte lowest
  function automatic logic [63:0] expectWord(input int i);
    logic [63:0] w;
    logic [23:0] a;
    int          k;
    w = '0;
    for (k = 0; k < 8; k++) begin
      a = progStart + 24'(8 * i + k);
      w[8*k +: 8] = flashByte(a);
    end
    return w;
  endfunction

  task automatic stopWithFailure(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic failValue(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    stopWithFailure($sformatf("FAILED %s: expected %h actual %h", name, expected, actual));
  endtask

  task automatic pulseStart();
    @(posedge AClkH);
    #1 loadStart = 1'b1;
    @(posedge AClkH);
    #1 loadStart = 1'b0;
  endtask

  task automatic waitActive(input logic level, input int limit, input string what);
    int cycles;
    cycles = 0;
    @(negedge AClkH);
    while (active !== level && cycles < limit) begin
      cycles++;
      @(negedge AClkH);
    end
    assert (active === level) else stopWithFailure({"timeout waiting for ", what});
  endtask

  // One full load, optionally with a start pulse while the load runs
  task automatic runLoad(input bit strayStart, input string name);
    int hdrBefore;
    hdrBefore = headerCount;
    writeIdx  = 0;
    pulseStart();
    waitActive(1'b1, 10, "active to rise");
    if (strayStart) begin
      repeat (100) @(posedge AClkH);
      assert (active === 1'b1) else stopWithFailure("load ended before the second start pulse");
      pulseStart();
    end
    waitActive(1'b0, loadTimeout, "active to fall");
    assert (flashNcs === 1'b1) else failValue({name, " ncs at end"}, 1, flashNcs);
    assert (writeIdx == romWords) else failValue({name, " write count"}, romWords, writeIdx);
    assert (headerCount == hdrBefore + 1)
      else failValue({name, " header count"}, hdrBefore + 1, headerCount);
    // Quiet gap to catch any late write
    repeat (50) @(negedge AClkH);
    assert (writeIdx == romWords) else failValue({name, " late writes"}, romWords, writeIdx);
  endtask

  always @(negedge AClkH) begin : writeCheck
    logic [memAddrW-1:0] expAddr;
    logic [63:0]         expData;
    if (arstN === 1'b1) begin
      if (memWrEn === 1'b1) begin
        assert (writeIdx < romWords) else stopWithFailure("write strobe after the last ROM word");
        expAddr = memAddrW'(romBase / 8 + writeIdx);
        expData = expectWord(writeIdx);
        assert (memAddr === expAddr) else failValue("rom write address", expAddr, memAddr);
        assert (memData === expData) else failValue("rom write data", expData, memData);
        writeIdx++;
      end
      if (active === 1'b1) begin
        assert (flashMaster === 1'b1) else failValue("master while active", 1, flashMaster);
        assert (memAccess === 1'b1) else failValue("access while active", 1, memAccess);
      end else begin
        assert (flashMaster === 1'b0) else failValue("master while idle", 0, flashMaster);
        assert (memAccess === 1'b0) else failValue("access while idle", 0, memAccess);
      end
      assert (headerError !== 1'b1) else stopWithFailure("flash model saw a bad read header");
    end
  end

  initial begin
    int cycles;
    loadStart = 1'b0;
    cycles = 0;
    while (arstN !== 1'b1 && cycles < 20) begin
      cycles++;
      @(posedge AClkH);
    end
    assert (arstN === 1'b1) else stopWithFailure("timeout waiting for reset release");
    repeat (3) @(posedge AClkH);

    @(negedge AClkH);
    assert (active === 1'b0) else failValue("idle active", 0, active);
    assert (flashMaster === 1'b0) else failValue("idle master", 0, flashMaster);
    assert (memAccess === 1'b0) else failValue("idle access", 0, memAccess);
    assert (memWrEn === 1'b0) else failValue("idle write enable", 0, memWrEn);
    assert (flashNcs === 1'b1) else failValue("idle ncs", 1, flashNcs);
    assert (flashSck === 1'b0) else failValue("idle sck", 0, flashSck);
    assert (flashMosi === 1'b0) else failValue("idle mosi", 0, flashMosi);

    runLoad(1'b1, "first load");
    runLoad(1'b0, "reload");

    $display("TEST OK");
    $finish;
  end

endmodule

// ==== flist.f ====
logic/flashLoadPkg.sv
logic/spiByteEngine.sv
logic/romWordPacker.sv
logic/loadSequencer.sv
logic/flashLoader.sv
verification/tbClockGen.sv
verification/spiFlashModel.sv
verification/flashLoaderTb.sv
